//--- Makefile
VERILATOR ?= verilator
TB_TOP    ?= tb_cpu_pin_bridge
FILELIST  ?= cpu_pin_bridge.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= >>> PASS

SIM_BIN := $(OBJ_DIR)/V$(TB_TOP)
SOURCES := $(wildcard src/*.sv testbench/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN) 2>&1)"; echo "$$out"; echo "$$out" | grep -qxF -- '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

//--- cpu_pin_bridge.f
src/apb_pkg.sv
src/pin_bus_pkg.sv
src/apb_frontend.sv
src/byte_lane.sv
src/pin_sequencer.sv
src/cpu_pin_bridge.sv
testbench/tb_cpu_pin_bridge.sv

//--- src/apb_frontend.sv
// APB slave side of the bridge. Checks alignment, launches one pin-bus
// transfer per access and answers with pready once the sequencer is done.
// Misaligned accesses are refused with pslverr and never reach the pins.

module apb_frontend (
  input  logic               clk,
  input  logic               arst_n,
  input  logic               psel,
  input  logic               penable,
  input  logic               pwrite,
  input  apb_pkg::apb_addr_t paddr,
  input  apb_pkg::apb_data_t pwdata,
  output apb_pkg::apb_data_t prdata,
  output logic               pready,
  output logic               pslverr,
  output apb_pkg::bus_req_t  req,
  output logic               load,
  output logic               start,
  input  logic               done,
  input  apb_pkg::apb_data_t rdata_word
);

  import apb_pkg::*;

  typedef enum logic [1:0] {
    FE_IDLE,  // Waiting for an access phase
    FE_BUSY,  // Pin transfer in flight
    FE_RESP   // pready cycle
  } fe_state_t;

  fe_state_t state;
  logic      wr_q;          // Direction of the transfer being answered
  logic      first_access;
  logic      aligned;
  logic      launch;

  // Only an idle frontend sees the first cycle of psel and penable
  assign first_access = (state == FE_IDLE) && psel && penable;
  assign aligned      = (paddr[1:0] == 2'b00);
  assign launch       = first_access && aligned;

  // Lanes and sequencer take the request in access cycle 1
  assign req   = '{addr: paddr, wdata: pwdata, write: pwrite};
  assign load  = launch;
  assign start = launch;

  // Lanes hold the full word by the response cycle
  assign prdata = (state == FE_RESP && !wr_q && !pslverr) ? rdata_word : '0;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state   <= FE_IDLE;
      wr_q    <= 1'b0;
      pready  <= 1'b0;
      pslverr <= 1'b0;
    end else begin
      case (state)
        FE_IDLE: begin
          if (first_access) begin
            wr_q <= pwrite;
            if (aligned) begin
              state <= FE_BUSY;
            end else begin
              state   <= FE_RESP;  // Error answer in cycle 2
              pready  <= 1'b1;
              pslverr <= 1'b1;
            end
          end
        end
        FE_BUSY: begin
          if (done) begin
            state  <= FE_RESP;
            pready <= 1'b1;
          end
        end
        default: begin
          state   <= FE_IDLE;
          pready  <= 1'b0;
          pslverr <= 1'b0;
        end
      endcase
    end
  end

  // Sequencer only finishes a transfer that this side launched
  a_done_when_busy: assert property (@(posedge clk) disable iff (!arst_n)
    done |-> state == FE_BUSY);

  // pready only ever answers an access phase of the host
  a_pready_in_access: assert property (@(posedge clk) disable iff (!arst_n)
    pready |-> psel && penable);

endmodule : apb_frontend

//--- src/apb_pkg.sv
// APB-side types shared by the bridge frontend, the byte lanes and the testbench.
// Import inside a module body; use scoped names for ports in module headers.

package apb_pkg;

  localparam int unsigned APB_ADDR_W = 32;
  localparam int unsigned APB_DATA_W = 32;

  // Byte address as seen by the host
  typedef logic [APB_ADDR_W-1:0] apb_addr_t;

  // One APB data word
  typedef logic [APB_DATA_W-1:0] apb_data_t;

  // Request captured at the first access cycle, broadcast to the lanes
  typedef struct packed {
    apb_addr_t addr;   // Word-aligned target address
    apb_data_t wdata;  // Write data, ignored on reads
    logic      write;  // 1 for a write transfer
  } bus_req_t;

endpackage : apb_pkg

//--- src/byte_lane.sv
// One byte slice of the bridge datapath. Stores its address and write-data
// byte on load, presents them while selected for the address phase and
// captures one read byte from the pins while selected for the read phase.

module byte_lane #(
  parameter int unsigned LANE_IDX = 0
) (
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic                  load,
  input  apb_pkg::bus_req_t     req,
  input  pin_bus_pkg::lane_sel_t addr_sel,
  input  pin_bus_pkg::lane_sel_t read_sel,
  input  pin_bus_pkg::pin_byte_t din,
  output pin_bus_pkg::pin_byte_t addr_byte,
  output pin_bus_pkg::pin_byte_t wdata_byte,
  output pin_bus_pkg::pin_byte_t rdata_byte
);

  import apb_pkg::*;
  import pin_bus_pkg::*;

  pin_byte_t addr_q;
  pin_byte_t wdata_q;
  pin_byte_t rdata_q;

  always_ff @(posedge clk) begin
    if (load) begin
      addr_q  <= req.addr[LANE_IDX*BYTE_W +: BYTE_W];
      // Reads put zeros on the data pins
      wdata_q <= req.write ? req.wdata[LANE_IDX*BYTE_W +: BYTE_W] : '0;
    end
    if (read_sel[LANE_IDX]) begin
      rdata_q <= din;  // Sampled at the end of this lane's read cycle
    end
  end

  // Zero when not selected so the sequencer can OR all lanes together
  assign addr_byte  = addr_sel[LANE_IDX] ? addr_q : '0;
  assign wdata_byte = addr_sel[LANE_IDX] ? wdata_q : '0;
  assign rdata_byte = rdata_q;

  // Address and read phases never overlap on the pins
  a_sel_exclusive: assert property (@(posedge clk) disable iff (!arst_n)
    (addr_sel & read_sel) == '0);

endmodule : byte_lane

//--- src/cpu_pin_bridge.sv
// Bridge from a 32-bit APB slave port to an 8-bit external pin bus.
// Each transfer sends four address bytes, with write data alongside on
// writes, and collects four read bytes from bus_din on reads.

module cpu_pin_bridge (
  input  logic                   clk,
  input  logic                   arst_n,
  input  logic                   psel,
  input  logic                   penable,
  input  logic                   pwrite,
  input  apb_pkg::apb_addr_t     paddr,
  input  apb_pkg::apb_data_t     pwdata,
  output apb_pkg::apb_data_t     prdata,
  output logic                   pready,
  output logic                   pslverr,
  output logic                   bus_frame,
  output pin_bus_pkg::pin_byte_t bus_addr,
  output pin_bus_pkg::pin_byte_t bus_dout,
  output logic                   bus_oe,
  input  pin_bus_pkg::pin_byte_t bus_din
);

  import apb_pkg::*;
  import pin_bus_pkg::*;

  bus_req_t               req;
  logic                   load;
  logic                   start;
  logic                   done;
  lane_sel_t              addr_sel;
  lane_sel_t              read_sel;
  pin_byte_t [LANES-1:0]  addr_bytes;
  pin_byte_t [LANES-1:0]  wdata_bytes;
  pin_byte_t [LANES-1:0]  rdata_bytes;
  apb_data_t              rdata_word;

  assign rdata_word = rdata_bytes;  // Lane k is byte k of the word

  apb_frontend u_frontend (
    .clk        (clk),
    .arst_n     (arst_n),
    .psel       (psel),
    .penable    (penable),
    .pwrite     (pwrite),
    .paddr      (paddr),
    .pwdata     (pwdata),
    .prdata     (prdata),
    .pready     (pready),
    .pslverr    (pslverr),
    .req        (req),
    .load       (load),
    .start      (start),
    .done       (done),
    .rdata_word (rdata_word)
  );

  for (genvar k = 0; k < LANES; k++) begin : g_lane
    byte_lane #(.LANE_IDX(k)) u_lane (
      .clk        (clk),
      .arst_n     (arst_n),
      .load       (load),
      .req        (req),
      .addr_sel   (addr_sel),
      .read_sel   (read_sel),
      .din        (bus_din),
      .addr_byte  (addr_bytes[k]),
      .wdata_byte (wdata_bytes[k]),
      .rdata_byte (rdata_bytes[k])
    );
  end

  pin_sequencer u_sequencer (
    .clk         (clk),
    .arst_n      (arst_n),
    .start       (start),
    .write       (req.write),
    .done        (done),
    .addr_sel    (addr_sel),
    .read_sel    (read_sel),
    .addr_bytes  (addr_bytes),
    .wdata_bytes (wdata_bytes),
    .bus_frame   (bus_frame),
    .bus_addr    (bus_addr),
    .bus_dout    (bus_dout),
    .bus_oe      (bus_oe)
  );

endmodule : cpu_pin_bridge

//--- src/pin_bus_pkg.sv
// Types for the narrow external pin bus and its phase sequencer.
// A word crosses the pins as LANES bytes, least significant byte first.

package pin_bus_pkg;

  localparam int unsigned BYTE_W = 8;
  localparam int unsigned LANES  = 4;  // Bytes per APB word

  // One byte on the pin bus
  typedef logic [BYTE_W-1:0] pin_byte_t;

  // One-hot lane select, bit k picks byte k
  typedef logic [LANES-1:0] lane_sel_t;

  // Sequencer phases
  typedef enum logic [1:0] {
    IDLE,  // No frame on the pins
    ADDR,  // Address and write data go out
    READ   // External device drives bus_din
  } seq_state_t;

endpackage : pin_bus_pkg

//--- src/pin_sequencer.sv
// Walks the pin-bus phases of one transfer: four address cycles, then four
// read cycles for reads only. Drives the one-hot lane selects and the frame
// and output enable pins. Address and write data come from the lanes.

module pin_sequencer (
  input  logic                                       clk,
  input  logic                                       arst_n,
  input  logic                                       start,
  input  logic                                       write,
  output logic                                       done,
  output pin_bus_pkg::lane_sel_t                     addr_sel,
  output pin_bus_pkg::lane_sel_t                     read_sel,
  input  pin_bus_pkg::pin_byte_t [pin_bus_pkg::LANES-1:0] addr_bytes,
  input  pin_bus_pkg::pin_byte_t [pin_bus_pkg::LANES-1:0] wdata_bytes,
  output logic                                       bus_frame,
  output pin_bus_pkg::pin_byte_t                     bus_addr,
  output pin_bus_pkg::pin_byte_t                     bus_dout,
  output logic                                       bus_oe
);

  import pin_bus_pkg::*;

  seq_state_t                 state;
  logic [$clog2(LANES)-1:0]   cnt;   // Byte position within the phase
  logic                       wr_q;
  logic                       last;

  assign last = &cnt;  // LANES is a power of two

  // Writes end after the address phase and reads after the read phase
  assign done = last && ((state == ADDR && wr_q) || state == READ);

  // Unselected lanes drive zero
  always_comb begin
    bus_addr = '0;
    bus_dout = '0;
    for (int k = 0; k < LANES; k++) begin
      bus_addr = bus_addr | addr_bytes[k];
      bus_dout = bus_dout | wdata_bytes[k];
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state     <= IDLE;
      cnt       <= '0;
      wr_q      <= 1'b0;
      addr_sel  <= '0;
      read_sel  <= '0;
      bus_frame <= 1'b0;
      bus_oe    <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          if (start) begin
            state     <= ADDR;
            cnt       <= '0;
            wr_q      <= write;
            addr_sel  <= lane_sel_t'(1);  // Least significant byte first
            bus_frame <= 1'b1;
            bus_oe    <= write;
          end
        end
        ADDR: begin
          if (last) begin
            cnt      <= '0;
            addr_sel <= '0;
            bus_oe   <= 1'b0;
            if (wr_q) begin
              state     <= IDLE;
              bus_frame <= 1'b0;
            end else begin
              state    <= READ;
              read_sel <= lane_sel_t'(1);
            end
          end else begin
            cnt      <= cnt + 1'b1;
            addr_sel <= addr_sel << 1;
          end
        end
        READ: begin
          if (last) begin
            state     <= IDLE;
            cnt       <= '0;
            read_sel  <= '0;
            bus_frame <= 1'b0;
          end else begin
            cnt      <= cnt + 1'b1;
            read_sel <= read_sel << 1;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Data pins carry zero whenever they are not driven
  a_dout_zero_without_oe: assert property (@(posedge clk) disable iff (!arst_n)
    !bus_oe |-> bus_dout == '0);

  // The frontend never launches into a running frame
  a_start_when_idle: assert property (@(posedge clk) disable iff (!arst_n)
    start |-> state == IDLE);

endmodule : pin_sequencer

//--- testbench/tb_cpu_pin_bridge.sv
// Testbench for the APB to pin-bus bridge. Random APB traffic from a fixed
// seed runs against a pin-level device model. Every response, latency and
// pin frame is checked against a reference memory kept on the host side.

module tb_cpu_pin_bridge;

  timeunit 1ns;
  timeprecision 1ps;

  import apb_pkg::*;
  import pin_bus_pkg::*;

  localparam int        N_RAND    = 300;
  localparam int        TIMEOUT   = N_RAND * 12 + 100;  // A read takes 12 cycles with setup
  localparam int        N_ADDRS   = 16;
  localparam apb_addr_t ADDR_BASE = 32'h8000_1000;

  logic      clk;
  logic      arst_n;
  logic      psel;
  logic      penable;
  logic      pwrite;
  apb_addr_t paddr;
  apb_data_t pwdata;
  apb_data_t prdata;
  logic      pready;
  logic      pslverr;
  logic      bus_frame;
  pin_byte_t bus_addr;
  pin_byte_t bus_dout;
  logic      bus_oe;
  pin_byte_t bus_din = 8'hee;  // Idle pattern the bridge must ignore

  integer seed     = 33;
  int     cycles   = 0;
  int     n_checks = 0;

  apb_data_t pin_mem [apb_addr_t];  // Device behind the pins
  apb_data_t ref_mem [apb_addr_t];  // Expected contents

  // Pin model state and a copy of the last finished frame
  int        fidx      = 0;
  int        cur_oe    = 0;
  apb_addr_t cur_addr  = '0;
  apb_data_t cur_wdata = '0;
  int        frames    = 0;
  int        seen_oe   = 0;
  int        seen_len  = 0;
  apb_addr_t seen_addr = '0;
  apb_data_t seen_wdata = '0;

  cpu_pin_bridge cpu_pin_bridge_inst (
    .clk       (clk),
    .arst_n    (arst_n),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .paddr     (paddr),
    .pwdata    (pwdata),
    .prdata    (prdata),
    .pready    (pready),
    .pslverr   (pslverr),
    .bus_frame (bus_frame),
    .bus_addr  (bus_addr),
    .bus_dout  (bus_dout),
    .bus_oe    (bus_oe),
    .bus_din   (bus_din)
  );

  always #5 clk = ~clk;

  always @(posedge clk) begin
    cycles++;
    if (cycles > TIMEOUT) begin
      abort_run($sformatf("Timeout, the run did not finish within %0d cycles", TIMEOUT));
    end
  end

  // Fill pattern for words never written depends on every address bit
  function automatic apb_data_t fill_word(input apb_addr_t a);
    return {a[15:0], ~a[31:16]} ^ 32'h5a3c_96e1;
  endfunction

  function automatic apb_data_t pin_word(input apb_addr_t a);
    return pin_mem.exists(a) ? pin_mem[a] : fill_word(a);
  endfunction

  function automatic apb_data_t expected_word(input apb_addr_t a);
    return ref_mem.exists(a) ? ref_mem[a] : fill_word(a);
  endfunction

  function automatic apb_addr_t rand_addr();
    int idx;
    idx = $unsigned($random(seed)) % N_ADDRS;
    return ADDR_BASE + apb_addr_t'(idx * 4);
  endfunction

  // Pin-level device that looks at the pins once they settled after the edge
  always @(posedge clk) begin : pin_model
    apb_data_t word;
    #1;
    if (bus_frame) begin
      if (bus_oe) cur_oe++;
      if (fidx < LANES) begin
        cur_addr[fidx*8 +: 8]  = bus_addr;  // Byte k in frame cycle k
        cur_wdata[fidx*8 +: 8] = bus_dout;
        bus_din                = 8'hee;
      end else begin
        word    = pin_word(cur_addr);
        bus_din = word[(fidx-LANES)*8 +: 8];  // Sampled at the end of this cycle
      end
      fidx++;
    end else begin
      bus_din = 8'hee;
      if (fidx > 0) begin  // Frame just ended
        frames++;
        seen_addr  = cur_addr;
        seen_wdata = cur_wdata;
        seen_oe    = cur_oe;
        seen_len   = fidx;
        if (cur_oe == LANES) pin_mem[cur_addr] = cur_wdata;
        fidx   = 0;
        cur_oe = 0;
      end
    end
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display(">>> FAIL");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_eq(input string test, input string what,
                          input logic [31:0] exp, input logic [31:0] act);
    n_checks++;
    assert (act === exp)
      else abort_run($sformatf("ERR %s: %s expected 0x%08h actual 0x%08h",
                               test, what, exp, act));
  endtask

  // One APB transfer with lat counting access cycles up to and including pready
  task automatic apb_access(input logic wr, input apb_addr_t a, input apb_data_t d,
                            output apb_data_t rd, output logic err, output int lat);
    logic got;
    got = 1'b0;
    lat = 0;
    rd  = '0;
    err = 1'b0;
    @(posedge clk);
    #1;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = a;
    pwdata  = d;
    @(posedge clk);
    #1;
    penable = 1'b1;
    while (!got) begin
      lat++;
      @(negedge clk);
      if (pready) begin
        got = 1'b1;
        rd  = prdata;
        err = pslverr;
      end
    end
    @(posedge clk);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic do_write(input apb_addr_t a, input apb_data_t d, input string test);
    apb_data_t rd;
    logic      err;
    int        lat;
    int        frames_before;
    frames_before = frames;
    apb_access(1'b1, a, d, rd, err, lat);
    check_eq(test, "write latency", 6, lat);
    check_eq(test, "pslverr", 0, 32'(err));
    check_eq(test, "frame count", frames_before + 1, frames);
    check_eq(test, "pin address", a, seen_addr);
    check_eq(test, "pin write data", d, seen_wdata);
    check_eq(test, "bus_oe cycles", LANES, seen_oe);
    check_eq(test, "frame cycles", LANES, seen_len);
    ref_mem[a] = d;
  endtask

  task automatic do_read(input apb_addr_t a, input string test, output apb_data_t rd);
    logic err;
    int   lat;
    int   frames_before;
    frames_before = frames;
    apb_access(1'b0, a, '0, rd, err, lat);
    check_eq(test, "read latency", 10, lat);
    check_eq(test, "pslverr", 0, 32'(err));
    check_eq(test, "frame count", frames_before + 1, frames);
    check_eq(test, "pin address", a, seen_addr);
    check_eq(test, "bus_oe cycles", 0, seen_oe);
    check_eq(test, "frame cycles", 2 * LANES, seen_len);
    check_eq(test, "read data", expected_word(a), rd);
  endtask

  task automatic do_misaligned(input logic wr, input apb_addr_t a, input apb_data_t d,
                               input string test);
    apb_data_t rd;
    logic      err;
    int        lat;
    apb_access(wr, a, d, rd, err, lat);
    check_eq(test, "error latency", 2, lat);
    check_eq(test, "pslverr", 1, 32'(err));
    check_eq(test, "open frame cycles", 0, fidx);
  endtask

  initial begin
    apb_addr_t a;
    apb_data_t d;
    apb_data_t rd;
    int        kind;
    clk     = 1'b0;
    arst_n  = 1'b0;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    repeat (5) @(posedge clk);
    #1;
    arst_n = 1'b1;

    a = rand_addr();
    d = $random(seed);
    do_write(a, d, "write_read_back");
    do_read(a, "write_read_back", rd);
    check_eq("write_read_back", "read back word", d, rd);
    do_write(rand_addr(), $random(seed), "write_timing");
    do_read(ADDR_BASE + 32'h100, "read_timing", rd);  // Never written
    a = rand_addr();
    do_misaligned(1'b1, a | 32'h1, $random(seed), "misaligned_write");
    do_read(a, "misaligned_write", rd);  // Word behind the refused write is unchanged
    do_misaligned(1'b0, rand_addr() | 32'h3, 32'h0, "misaligned_read");

    for (int i = 0; i < N_RAND; i++) begin
      kind = $unsigned($random(seed)) % 8;
      a    = rand_addr();
      d    = $random(seed);
      if (kind < 3) begin
        do_write(a, d, "random_mix");
      end else if (kind < 7) begin
        do_read(a, "random_mix", rd);
      end else begin
        do_misaligned(d[4], a + apb_addr_t'(1 + ($unsigned(d) % 3)), d, "random_mix");
      end
    end

    if (n_checks > 0) begin
      $display(">>> PASS");
      $finish;
    end else begin
      abort_run("No checks were run");
    end
  end

endmodule : tb_cpu_pin_bridge
